// File: hw/epu_buffer.sv
`timescale 1ns/1ps
`include "epu_params.svh"

module epu_buffer #(
    parameter type elem_t = epu_core_pkg::acc_t
) (
    input  logic                   clk,
    input  logic                   busy_i,
    input  logic                   sel_i,
    input  epu_core_pkg::buf_req_t bus_req_i,
    input  elem_t                  bus_wdata_i,
    input  epu_core_pkg::buf_req_t eng_req_i,
    input  elem_t                  eng_wdata_i,
    output elem_t                  rdata_o
);

    elem_t                  mem [`EPU_BUF_DEPTH];
    epu_core_pkg::buf_req_t req;
    elem_t                  wdata;

    // Engine owns the port while it runs
    always_comb begin
        if (busy_i) begin
            req   = eng_req_i;
            wdata = eng_wdata_i;
        end else begin
            req    = bus_req_i;
            // Bus request only counts when this buffer is addressed
            req.en = bus_req_i.en && sel_i;
            req.we = bus_req_i.we && sel_i;
            wdata  = bus_wdata_i;
        end
    end

    // One-cycle read latency, output holds until the next read
    always_ff @(posedge clk) begin
        if (req.en) begin
            if (req.we)
                mem[req.idx] <= wdata;
            else
                rdata_o <= mem[req.idx];
        end
    end

endmodule

// File: hw/epu_bus_pkg.sv
`include "epu_params.svh"

package epu_bus_pkg;

    // Address channel, shared by AW and AR
    typedef struct packed {
        logic [`EPU_ADDR_BITS-1:0] addr;
        logic [`EPU_ID_BITS-1:0]   id;
        // Beats minus one
        logic [`EPU_LEN_BITS-1:0]  len;
    } addr_chan_t;

    // Write data beat
    // Full-word writes only, so no strobes
    typedef struct packed {
        logic [`EPU_DATA_BITS-1:0] data;
        logic                      last;
    } wdata_chan_t;

    // Read data beat
    typedef struct packed {
        logic [`EPU_DATA_BITS-1:0] data;
        logic [`EPU_ID_BITS-1:0]   id;
        logic                      last;
    } rdata_chan_t;

    // Write response, always OKAY
    typedef struct packed {
        logic [`EPU_ID_BITS-1:0] id;
    } bresp_chan_t;

endpackage

// File: hw/epu_bus_slave.sv
`timescale 1ns/1ps
`include "epu_params.svh"

module epu_bus_slave (
    input  logic                        clk,
    input  logic                        rst,
    input  epu_bus_pkg::addr_chan_t     aw_i,
    input  logic                        aw_valid_i,
    output logic                        aw_ready_o,
    input  epu_bus_pkg::wdata_chan_t    w_i,
    input  logic                        w_valid_i,
    output logic                        w_ready_o,
    input  epu_bus_pkg::addr_chan_t     ar_i,
    input  logic                        ar_valid_i,
    output logic                        ar_ready_o,
    input  logic                        beat_take_i,
    input  logic                        busy_i,
    output epu_core_pkg::region_e       region_o,
    output logic [`EPU_ID_BITS-1:0]     id_o,
    output logic                        last_beat_o,
    output logic                        write_phase_o,
    output logic                        read_phase_o,
    output epu_core_pkg::buf_req_t      bus_req_o,
    output logic                        in_sel_o,
    output logic                        wgt_sel_o,
    output logic                        out_sel_o,
    output logic [`EPU_DATA_BITS-1:0]   wdata_o,
    output logic                        start_o
);

    typedef enum logic [1:0] {IDLE, WRITE, BRESP, READ} state_e;

    state_e                    state_q, state_d;
    epu_core_pkg::region_e     region_q, cur_region;
    logic [`EPU_ID_BITS-1:0]   id_q;
    logic [`EPU_LEN_BITS-1:0]  len_q, cnt_q;
    logic [`EPU_BUF_ABITS-1:0] idx_q;
    logic                      rd_avail_q, start_q;
    logic                      aw_hs, ar_hs, w_hs, wr_ok, rd_issue;

    // 64 KiB page compare against each base
    function automatic epu_core_pkg::region_e decode(input logic [`EPU_ADDR_BITS-1:0] addr);
        case (addr & ~`EPU_SPAN_MASK)
            `EPU_BASE_INPUT:  return epu_core_pkg::INPUT;
            `EPU_BASE_OUTPUT: return epu_core_pkg::OUTPUT;
            `EPU_BASE_WEIGHT: return epu_core_pkg::WEIGHT;
            `EPU_BASE_CTRL:   return epu_core_pkg::CTRL;
            default:          return epu_core_pkg::NONE;
        endcase
    endfunction

    // Only IDLE takes a new request, AW before AR
    assign aw_ready_o = state_q == IDLE;
    assign ar_ready_o = (state_q == IDLE) && !aw_valid_i;
    assign w_ready_o  = state_q == WRITE;

    assign aw_hs = aw_valid_i && aw_ready_o;
    assign ar_hs = ar_valid_i && ar_ready_o;
    assign w_hs  = w_valid_i && w_ready_o;

    // Host may write input and weights, and only while the engine is idle
    assign wr_ok = !busy_i && (region_q == epu_core_pkg::INPUT || region_q == epu_core_pkg::WEIGHT);

    // First read goes out with the AR handshake, later ones once the mux took a beat
    assign rd_issue = ar_hs || (state_q == READ && beat_take_i && !last_beat_o);

    // Region still undecoded during the AR handshake cycle
    assign cur_region = (state_q == IDLE) ? decode(ar_i.addr) : region_q;
    assign in_sel_o   = cur_region == epu_core_pkg::INPUT;
    assign wgt_sel_o  = cur_region == epu_core_pkg::WEIGHT;
    assign out_sel_o  = cur_region == epu_core_pkg::OUTPUT;

    always_comb begin
        bus_req_o = '0;
        if (rd_issue) begin
            bus_req_o.en  = 1'b1;
            bus_req_o.idx = ar_hs ? ar_i.addr[`EPU_BUF_ABITS+1:2] : idx_q;
        end else if (w_hs && wr_ok) begin
            bus_req_o.en  = 1'b1;
            bus_req_o.we  = 1'b1;
            bus_req_o.idx = idx_q;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (aw_hs)
                    state_d = WRITE;
                else if (ar_hs)
                    state_d = READ;
            end
            WRITE: if (w_hs && w_i.last) state_d = BRESP;
            // beat_take_i doubles as the B handshake here
            BRESP: if (beat_take_i) state_d = IDLE;
            READ:  if (beat_take_i && last_beat_o) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q    <= IDLE;
            region_q   <= epu_core_pkg::NONE;
            cnt_q      <= '0;
            idx_q      <= '0;
            rd_avail_q <= 1'b0;
            start_q    <= 1'b0;
        end else begin
            state_q    <= state_d;
            // Word sits on the buffer output until the mux takes it
            rd_avail_q <= rd_issue || (rd_avail_q && !beat_take_i);
            start_q    <= w_hs && region_q == epu_core_pkg::CTRL && w_i.data[0];
            if (aw_hs) begin
                region_q <= decode(aw_i.addr);
                cnt_q    <= '0;
                idx_q    <= aw_i.addr[`EPU_BUF_ABITS+1:2];
            end else if (ar_hs) begin
                region_q <= decode(ar_i.addr);
                cnt_q    <= '0;
                idx_q    <= ar_i.addr[`EPU_BUF_ABITS+1:2] + 1'b1;
            end else begin
                if (w_hs || (state_q == READ && beat_take_i))
                    cnt_q <= cnt_q + 1'b1;
                // Dropped writes still advance the index
                if (w_hs || rd_issue)
                    idx_q <= idx_q + 1'b1;
            end
        end
    end

    // Burst id and length
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            id_q  <= aw_i.id;
            len_q <= aw_i.len;
        end else if (ar_hs) begin
            id_q  <= ar_i.id;
            len_q <= ar_i.len;
        end
    end

    assign region_o      = region_q;
    assign id_o          = id_q;
    assign last_beat_o   = cnt_q == len_q;
    assign write_phase_o = state_q == BRESP;
    assign read_phase_o  = rd_avail_q;
    assign wdata_o       = w_i.data;
    assign start_o       = start_q;

endmodule

// File: hw/epu_core_pkg.sv
`include "epu_params.svh"

package epu_core_pkg;

    // Address regions seen by the bus slave
    typedef enum logic [2:0] {
        NONE,
        INPUT,
        OUTPUT,
        WEIGHT,
        CTRL
    } region_e;

    // Element types held in the buffers
    typedef logic signed [7:0]  act_t;
    typedef logic signed [7:0]  wgt_t;
    typedef logic signed [31:0] acc_t;

    // One buffer access
    typedef struct packed {
        logic                      en;
        logic                      we;
        logic [`EPU_BUF_ABITS-1:0] idx;
    } buf_req_t;

endpackage

// File: hw/epu_mac_engine.sv
`timescale 1ns/1ps
`include "epu_params.svh"

module epu_mac_engine (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    output logic                   busy_o,
    output logic                   done_o,
    output epu_core_pkg::buf_req_t in_req_o,
    output epu_core_pkg::buf_req_t wgt_req_o,
    output epu_core_pkg::buf_req_t out_req_o,
    input  epu_core_pkg::act_t     in_rdata_i,
    input  epu_core_pkg::wgt_t     wgt_rdata_i,
    output epu_core_pkg::acc_t     out_wdata_o
);

    localparam logic [`EPU_BUF_ABITS-1:0] K_LAST = `EPU_BUF_ABITS'(`EPU_VEC_LEN - 1);
    localparam logic [`EPU_BUF_ABITS-1:0] O_LAST = `EPU_BUF_ABITS'(`EPU_N_OUT - 1);

    logic                      issue_q, mac_q, done_q;
    logic [`EPU_BUF_ABITS-1:0] k_q, o_q, k2_q, o2_q;
    epu_core_pkg::acc_t        acc_q, prod, sum;
    logic                      row_end, go;

    assign go = start_i && !busy_o;

    // Stage two, operands arrive one cycle after the read
    assign prod    = epu_core_pkg::acc_t'(in_rdata_i) * epu_core_pkg::acc_t'(wgt_rdata_i);
    assign sum     = acc_q + prod;
    assign row_end = mac_q && (k2_q == K_LAST);

    // Stage one reads
    assign in_req_o  = '{en: issue_q, we: 1'b0, idx: k_q};
    assign wgt_req_o = '{en: issue_q, we: 1'b0,
                         idx: `EPU_BUF_ABITS'(o_q * `EPU_VEC_LEN + k_q)};

    // Finished row goes straight to the output buffer
    assign out_req_o   = '{en: row_end, we: row_end, idx: o2_q};
    assign out_wdata_o = sum;

    assign busy_o = issue_q || mac_q;
    assign done_o = done_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            issue_q <= 1'b0;
            mac_q   <= 1'b0;
            done_q  <= 1'b0;
            k_q     <= '0;
            o_q     <= '0;
            k2_q    <= '0;
            o2_q    <= '0;
        end else begin
            if (go) begin
                issue_q <= 1'b1;
                done_q  <= 1'b0;
                k_q     <= '0;
                o_q     <= '0;
            end else if (issue_q) begin
                if (k_q == K_LAST) begin
                    k_q <= '0;
                    o_q <= o_q + 1'b1;
                    // Last read of the last row
                    if (o_q == O_LAST)
                        issue_q <= 1'b0;
                end else begin
                    k_q <= k_q + 1'b1;
                end
            end
            // Indices follow the read into stage two
            mac_q <= issue_q;
            k2_q  <= k_q;
            o2_q  <= o_q;
            if (row_end && o2_q == O_LAST)
                done_q <= 1'b1;
        end
    end

    // Accumulator restarts at each row
    always_ff @(posedge clk) begin
        if (go)
            acc_q <= '0;
        else if (mac_q)
            acc_q <= row_end ? '0 : sum;
    end

endmodule

// File: hw/epu_params.svh
`ifndef EPU_PARAMS_SVH
`define EPU_PARAMS_SVH

// Bus field widths
`define EPU_ADDR_BITS 32
`define EPU_DATA_BITS 32
`define EPU_ID_BITS 4
// Beats minus one, as on the bus
`define EPU_LEN_BITS 4

// On-chip buffers
`define EPU_BUF_DEPTH 16
`define EPU_BUF_ABITS 4

// Dot-product shape
`define EPU_VEC_LEN 4
`define EPU_N_OUT 4

// Region bases, each one 64 KiB wide
`define EPU_BASE_INPUT 32'h5000_0000
`define EPU_BASE_OUTPUT 32'h6000_0000
`define EPU_BASE_WEIGHT 32'h7400_0000
`define EPU_BASE_CTRL 32'h8000_0000
`define EPU_SPAN_MASK 32'h0000_ffff

`endif

// File: hw/epu_read_mux.sv
`timescale 1ns/1ps
`include "epu_params.svh"

module epu_read_mux (
    input  logic                        clk,
    input  logic                        rst,
    input  epu_core_pkg::region_e       region_i,
    input  logic                        read_phase_i,
    input  logic                        write_phase_i,
    input  logic                        last_beat_i,
    input  logic [`EPU_ID_BITS-1:0]     id_i,
    input  logic                        busy_i,
    input  logic                        done_i,
    input  epu_core_pkg::act_t          in_rdata_i,
    input  epu_core_pkg::wgt_t          wgt_rdata_i,
    input  epu_core_pkg::acc_t          out_rdata_i,
    output epu_bus_pkg::rdata_chan_t    r_o,
    output logic                        r_valid_o,
    input  logic                        r_ready_i,
    output logic                        beat_take_o,
    output epu_bus_pkg::bresp_chan_t    b_o,
    output logic                        b_valid_o,
    input  logic                        b_ready_i
);

    logic [`EPU_DATA_BITS-1:0] rd_word;
    logic                      load;

    // Buffers belong to the engine while busy, so they read as zero
    always_comb begin
        case (region_i)
            epu_core_pkg::INPUT:  rd_word = busy_i ? '0 : `EPU_DATA_BITS'(in_rdata_i);
            epu_core_pkg::WEIGHT: rd_word = busy_i ? '0 : `EPU_DATA_BITS'(wgt_rdata_i);
            epu_core_pkg::OUTPUT: rd_word = busy_i ? '0 : out_rdata_i;
            // Status word, bit 0 busy and bit 1 done
            epu_core_pkg::CTRL:   rd_word = {{(`EPU_DATA_BITS-2){1'b0}}, done_i, busy_i};
            default:              rd_word = '0;
        endcase
    end

    // New beat only into an empty holding register
    assign load        = read_phase_i && !r_valid_o;
    // Also tells the slave when the B handshake is done
    assign beat_take_o = load || (write_phase_i && b_ready_i);

    // B held by the slave's response state
    assign b_valid_o = write_phase_i;
    assign b_o.id    = id_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            r_valid_o <= 1'b0;
        else if (load)
            r_valid_o <= 1'b1;
        else if (r_ready_i)
            r_valid_o <= 1'b0;
    end

    // r_last falls together with r_valid once the beat is taken
    always_ff @(posedge clk) begin
        if (load)
            r_o <= '{data: rd_word, id: id_i, last: last_beat_i};
        else if (r_ready_i)
            r_o.last <= 1'b0;
    end

endmodule

// File: hw/epu_top.sv
`timescale 1ns/1ps
`include "epu_params.svh"

module epu_top (
    input  logic                        clk,
    input  logic                        rst,
    input  epu_bus_pkg::addr_chan_t     aw_i,
    input  logic                        aw_valid_i,
    output logic                        aw_ready_o,
    input  epu_bus_pkg::wdata_chan_t    w_i,
    input  logic                        w_valid_i,
    output logic                        w_ready_o,
    output epu_bus_pkg::bresp_chan_t    b_o,
    output logic                        b_valid_o,
    input  logic                        b_ready_i,
    input  epu_bus_pkg::addr_chan_t     ar_i,
    input  logic                        ar_valid_i,
    output logic                        ar_ready_o,
    output epu_bus_pkg::rdata_chan_t    r_o,
    output logic                        r_valid_o,
    input  logic                        r_ready_i
);

    epu_core_pkg::region_e     region;
    logic [`EPU_ID_BITS-1:0]   id;
    logic [`EPU_DATA_BITS-1:0] wdata;
    logic                      last_beat, write_phase, read_phase, beat_take;
    logic                      in_sel, wgt_sel, out_sel, start, busy, done;
    epu_core_pkg::buf_req_t    bus_req, in_req, wgt_req, out_req;
    epu_core_pkg::act_t        in_rdata;
    epu_core_pkg::wgt_t        wgt_rdata;
    epu_core_pkg::acc_t        out_rdata, out_wdata;

    // Decode
    epu_bus_slave u_slave (
        .clk, .rst,
        .aw_i, .aw_valid_i, .aw_ready_o,
        .w_i, .w_valid_i, .w_ready_o,
        .ar_i, .ar_valid_i, .ar_ready_o,
        .beat_take_i(beat_take), .busy_i(busy),
        .region_o(region), .id_o(id), .last_beat_o(last_beat),
        .write_phase_o(write_phase), .read_phase_o(read_phase),
        .bus_req_o(bus_req), .in_sel_o(in_sel), .wgt_sel_o(wgt_sel), .out_sel_o(out_sel),
        .wdata_o(wdata), .start_o(start)
    );

    // Execute, buffers keep the low byte of each bus word
    epu_buffer #(.elem_t(epu_core_pkg::act_t)) u_in_buf (
        .clk, .busy_i(busy), .sel_i(in_sel),
        .bus_req_i(bus_req), .bus_wdata_i(epu_core_pkg::act_t'(wdata[7:0])),
        .eng_req_i(in_req), .eng_wdata_i('0), .rdata_o(in_rdata)
    );

    epu_buffer #(.elem_t(epu_core_pkg::wgt_t)) u_wgt_buf (
        .clk, .busy_i(busy), .sel_i(wgt_sel),
        .bus_req_i(bus_req), .bus_wdata_i(epu_core_pkg::wgt_t'(wdata[7:0])),
        .eng_req_i(wgt_req), .eng_wdata_i('0), .rdata_o(wgt_rdata)
    );

    epu_buffer #(.elem_t(epu_core_pkg::acc_t)) u_out_buf (
        .clk, .busy_i(busy), .sel_i(out_sel),
        .bus_req_i(bus_req), .bus_wdata_i(wdata),
        .eng_req_i(out_req), .eng_wdata_i(out_wdata), .rdata_o(out_rdata)
    );

    epu_mac_engine u_engine (
        .clk, .rst, .start_i(start), .busy_o(busy), .done_o(done),
        .in_req_o(in_req), .wgt_req_o(wgt_req), .out_req_o(out_req),
        .in_rdata_i(in_rdata), .wgt_rdata_i(wgt_rdata), .out_wdata_o(out_wdata)
    );

    // Result
    epu_read_mux u_mux (
        .clk, .rst, .region_i(region), .read_phase_i(read_phase),
        .write_phase_i(write_phase), .last_beat_i(last_beat), .id_i(id),
        .busy_i(busy), .done_i(done),
        .in_rdata_i(in_rdata), .wgt_rdata_i(wgt_rdata), .out_rdata_i(out_rdata),
        .r_o, .r_valid_o, .r_ready_i, .beat_take_o(beat_take),
        .b_o, .b_valid_o, .b_ready_i
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the EPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module epu_tb -f verilog.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Let bound assertion failures reach the testbench summary
out=$(./obj_dir/Vepu_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" <<< "$out"; then
    exit 0
fi
exit 1

// File: verif/epu_tb.sv
`timescale 1ns/1ps
`include "epu_params.svh"

module epu_tb;

    localparam int N_WGT    = `EPU_VEC_LEN * `EPU_N_OUT;
    localparam int POLL_MAX = 20;
    // Beats over all five tests, with every status poll at its limit
    localparam int TOTAL_BEATS     = 160 + 3 * POLL_MAX;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20;
    localparam logic [31:0] UNMAPPED   = 32'h9000_0000;
    // First page past the input region
    localparam logic [31:0] NEAR_INPUT = `EPU_BASE_INPUT + 32'h0001_0000;
    // Channel codes for wait_accept
    localparam int CH_AW = 0;
    localparam int CH_W  = 1;
    localparam int CH_AR = 2;

    logic                     clk;
    logic                     rst;
    epu_bus_pkg::addr_chan_t  aw;
    epu_bus_pkg::addr_chan_t  ar;
    epu_bus_pkg::wdata_chan_t w;
    epu_bus_pkg::bresp_chan_t b;
    epu_bus_pkg::rdata_chan_t r;
    logic                     aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic                     ar_valid, ar_ready, r_valid, r_ready;

    integer     seed;
    // 0 never stalls, 2 drops ready about half the time
    int         stall_lvl;
    int         err_cnt, check_cnt, test_cnt, test_fail_cnt, test_err_base;
    string      test_name;
    logic [3:0] next_id;

    logic [31:0] wr_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] got_q[$];

    // Reference copy of what the buffers should hold
    logic [31:0] in_words  [`EPU_VEC_LEN];
    logic [31:0] wgt_words [N_WGT];

    epu_top dut_i (
        .clk(clk), .rst(rst),
        .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
        .w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
        .b_o(b), .b_valid_o(b_valid), .b_ready_i(b_ready),
        .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
        .r_o(r), .r_valid_o(r_valid), .r_ready_i(r_ready)
    );

    always #4 clk = ~clk;

    // Buffers keep the low byte, reads give it back sign-extended
    function automatic logic [31:0] low_byte_signed(input logic [31:0] word);
        return {{24{word[7]}}, word[7:0]};
    endfunction

    function automatic logic [31:0] dot_product(input int o);
        int acc;
        int k;
        acc = 0;
        for (k = 0; k < `EPU_VEC_LEN; k++)
            acc += int'($signed(in_words[k][7:0]))
                 * int'($signed(wgt_words[o * `EPU_VEC_LEN + k][7:0]));
        return acc;
    endfunction

    function automatic logic ready_draw();
        return ($random(seed) & 3) >= stall_lvl;
    endfunction

    function automatic logic [3:0] take_id();
        next_id = next_id + 4'd1;
        return next_id;
    endfunction

    // Own checks plus bound assertion failures
    function automatic int errors_now();
        return err_cnt + dut_i.u_sva.fail_cnt;
    endfunction

    task automatic check_value(input string what, input int idx,
                               input logic [31:0] got, input logic [31:0] expv);
        check_cnt++;
        assert (got === expv) else begin
            $display("Error at %0d ns: %s [%0d] is %h, expected %h",
                     $time, what, idx, got, expv);
            err_cnt++;
        end
    endtask

    // Ready sampled mid-cycle, transfer happens at the next rising edge
    task automatic wait_accept(input int chan);
        logic hs;
        hs = 1'b0;
        while (!hs) begin
            @(negedge clk);
            case (chan)
                CH_AW:   hs = aw_ready;
                CH_W:    hs = w_ready;
                default: hs = ar_ready;
            endcase
            @(posedge clk);
            #1;
        end
    endtask

    // Sends wr_q as one burst and waits for the response
    task automatic write_burst(input logic [31:0] start_addr, input logic [3:0] id);
        int  i;
        logic hs;
        aw.addr  = start_addr;
        aw.id    = id;
        aw.len   = 4'(wr_q.size() - 1);
        aw_valid = 1'b1;
        wait_accept(CH_AW);
        aw_valid = 1'b0;
        for (i = 0; i < wr_q.size(); i++) begin
            w.data  = wr_q[i];
            w.last  = (i == wr_q.size() - 1);
            w_valid = 1'b1;
            wait_accept(CH_W);
        end
        w_valid = 1'b0;
        hs = 1'b0;
        while (!hs) begin
            b_ready = ready_draw();
            @(negedge clk);
            hs = b_valid && b_ready;
            if (hs)
                check_value("write response id", 0, 32'(b.id), 32'(id));
            @(posedge clk);
            #1;
        end
        b_ready = 1'b0;
        wr_q.delete();
    endtask

    // Collects the beats into got_q, id and last checked on the way
    task automatic read_burst(input logic [31:0] start_addr, input int beats,
                              input logic [3:0] id);
        int n;
        got_q.delete();
        ar.addr  = start_addr;
        ar.id    = id;
        ar.len   = 4'(beats - 1);
        ar_valid = 1'b1;
        wait_accept(CH_AR);
        ar_valid = 1'b0;
        n = 0;
        while (n < beats) begin
            r_ready = ready_draw();
            @(negedge clk);
            if (r_valid && r_ready) begin
                got_q.push_back(r.data);
                check_value("read id", n, 32'(r.id), 32'(id));
                check_value("read last", n, 32'(r.last), 32'(n == beats - 1));
                n++;
            end
            @(posedge clk);
            #1;
        end
        r_ready = 1'b0;
    endtask

    task automatic compare_beats(input string what);
        int i;
        check_value({what, " beat count"}, 0, 32'(got_q.size()), 32'(exp_q.size()));
        for (i = 0; i < exp_q.size() && i < got_q.size(); i++)
            check_value(what, i, got_q[i], exp_q[i]);
        exp_q.delete();
    endtask

    // Fresh random weights and inputs, model updated alongside
    task automatic load_operands();
        int i;
        for (i = 0; i < N_WGT; i++) begin
            wgt_words[i] = $random(seed);
            wr_q.push_back(wgt_words[i]);
        end
        write_burst(`EPU_BASE_WEIGHT, take_id());
        for (i = 0; i < `EPU_VEC_LEN; i++) begin
            in_words[i] = $random(seed);
            wr_q.push_back(in_words[i]);
        end
        write_burst(`EPU_BASE_INPUT, take_id());
    endtask

    task automatic check_operands();
        int i;
        read_burst(`EPU_BASE_WEIGHT, N_WGT, take_id());
        for (i = 0; i < N_WGT; i++)
            exp_q.push_back(low_byte_signed(wgt_words[i]));
        compare_beats("weight read");
        read_burst(`EPU_BASE_INPUT, `EPU_VEC_LEN, take_id());
        for (i = 0; i < `EPU_VEC_LEN; i++)
            exp_q.push_back(low_byte_signed(in_words[i]));
        compare_beats("input read");
    endtask

    task automatic start_engine();
        wr_q.push_back(32'h1);
        write_burst(`EPU_BASE_CTRL, take_id());
    endtask

    // Polls status bit 1
    task automatic wait_done();
        int          polls;
        logic [31:0] status;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < POLL_MAX) begin
            read_burst(`EPU_BASE_CTRL, 1, take_id());
            status = got_q[0];
            polls++;
        end
        if (!status[1]) begin
            $display("Engine did not report done within %0d status reads", POLL_MAX);
            err_cnt++;
        end else begin
            // Done set and busy already clear
            exp_q.push_back(32'h2);
            compare_beats("final status");
        end
    endtask

    task automatic check_outputs();
        int o;
        read_burst(`EPU_BASE_OUTPUT, `EPU_N_OUT, take_id());
        for (o = 0; o < `EPU_N_OUT; o++)
            exp_q.push_back(dot_product(o));
        compare_beats("output read");
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        test_err_base = errors_now();
        test_cnt++;
    endtask

    task automatic end_test();
        int errs;
        errs = errors_now() - test_err_base;
        if (errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errs);
            test_fail_cnt++;
        end
    endtask

    initial begin
        int i;
        seed      = 77;
        clk       = 1'b0;
        rst       = 1'b0;
        aw        = '0;
        ar        = '0;
        w         = '0;
        aw_valid  = 1'b0;
        w_valid   = 1'b0;
        b_ready   = 1'b0;
        ar_valid  = 1'b0;
        r_ready   = 1'b0;
        stall_lvl = 1;
        next_id   = '0;
        err_cnt   = 0;
        check_cnt = 0;
        test_cnt  = 0;
        test_fail_cnt = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        @(posedge clk);
        #1;

        begin_test("weight and input bursts");
        load_operands();
        check_operands();
        end_test();

        begin_test("engine run");
        start_engine();
        wait_done();
        check_outputs();
        end_test();

        begin_test("unmapped and output writes");
        read_burst(UNMAPPED, 4, take_id());
        for (i = 0; i < 4; i++)
            exp_q.push_back('0);
        compare_beats("unmapped read");
        for (i = 0; i < 4; i++)
            wr_q.push_back($random(seed));
        write_burst(NEAR_INPUT, take_id());
        for (i = 0; i < 4; i++)
            wr_q.push_back($random(seed));
        write_burst(`EPU_BASE_OUTPUT, take_id());
        read_burst(NEAR_INPUT, 4, take_id());
        for (i = 0; i < 4; i++)
            exp_q.push_back('0);
        compare_beats("unmapped read after write");
        check_outputs();
        check_operands();
        end_test();

        begin_test("heavy r and b stalls");
        stall_lvl = 2;
        load_operands();
        check_operands();
        start_engine();
        wait_done();
        check_outputs();
        end_test();

        // No stalls so the weight burst lands inside the busy window
        begin_test("weight write while busy");
        stall_lvl = 0;
        start_engine();
        for (i = 0; i < 4; i++)
            wr_q.push_back($random(seed));
        write_burst(`EPU_BASE_WEIGHT, take_id());
        read_burst(`EPU_BASE_CTRL, 1, take_id());
        exp_q.push_back(32'h1);
        compare_beats("status while busy");
        wait_done();
        check_outputs();
        check_operands();
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt, dut_i.u_sva.fail_cnt);
        if (test_fail_cnt == 0 && errors_now() == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // Stuck handshake guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a bus handshake never completed",
                 WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: verif/epu_tb_sva.sv
`timescale 1ns/1ps

module epu_tb_sva (
    input logic                     clk,
    input logic                     rst,
    input logic                     aw_ready_i,
    input logic                     w_ready_i,
    input epu_bus_pkg::rdata_chan_t r_i,
    input logic                     r_valid_i,
    input logic                     r_ready_i,
    input epu_bus_pkg::bresp_chan_t b_i,
    input logic                     b_valid_i,
    input logic                     b_ready_i
);

    // Failed assertions so far, summed into the testbench error count
    int fail_cnt = 0;

    // Stalled read beat keeps valid and payload
    r_hold: assert property (@(posedge clk) disable iff (!rst)
        r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
        else begin
            $error("read beat changed or was withdrawn while r_ready was low");
            fail_cnt++;
        end

    // Stalled write response keeps valid and id
    b_hold: assert property (@(posedge clk) disable iff (!rst)
        b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_i))
        else begin
            $error("write response changed or was withdrawn while b_ready was low");
            fail_cnt++;
        end

    // r_last only while a beat is valid
    r_last_valid: assert property (@(posedge clk) disable iff (!rst)
        r_i.last |-> r_valid_i)
        else begin
            $error("r_last high without r_valid");
            fail_cnt++;
        end

    // Reset leaves the slave idle
    // ar_ready left out, it drops whenever aw_valid is high
    reset_idle: assert property (@(posedge clk)
        !rst |=> !r_valid_i && !b_valid_i && !w_ready_i && aw_ready_i)
        else begin
            $error("bus outputs not idle after reset");
            fail_cnt++;
        end

endmodule

bind epu_top epu_tb_sva u_sva (
    .clk(clk),
    .rst(rst),
    .aw_ready_i(aw_ready_o),
    .w_ready_i(w_ready_o),
    .r_i(r_o),
    .r_valid_i(r_valid_o),
    .r_ready_i(r_ready_i),
    .b_i(b_o),
    .b_valid_i(b_valid_o),
    .b_ready_i(b_ready_i)
);

// File: verilog.f
+incdir+hw
hw/epu_bus_pkg.sv
hw/epu_core_pkg.sv
hw/epu_buffer.sv
hw/epu_bus_slave.sv
hw/epu_mac_engine.sv
hw/epu_read_mux.sv
hw/epu_top.sv
verif/epu_tb_sva.sv
verif/epu_tb.sv
